// ==== rtl/busMaster_macros.svh ====
`ifndef BUS_MASTER_MACROS_SVH
`define BUS_MASTER_MACROS_SVH

// data path
`define BM_DATA_WIDTH     8
`define BM_START_DATA     8'd10      // loaded on a start pulse
`define BM_ACK_BYTE       8'hCC      // upper byte of every good read

// addressing
`define BM_SLAVE_ID       3'd5

// frame lengths
`define BM_REQ_LEN        6          // 111 + slave id
`define BM_CTRL_LEN       7          // 111 + slave id + r/w

// cycle counts
`define BM_GRANT_WAIT     4          // idle cycles after the ack pattern
`define BM_DISPLAY_CYCLES 5          // disData high time

`endif

// ==== rtl/busMasterPkg.sv ====
`include "busMaster_macros.svh"

package busMasterPkg;

    typedef logic [`BM_DATA_WIDTH-1:0] dataByte;

    // ack byte arrives first, so it sits in the upper half
    typedef struct packed {
        dataByte ackByte;
        dataByte payload;
    } readWord;

    typedef enum logic {
        opRead  = 1'b0,
        opWrite = 1'b1
    } busOp;

    typedef enum logic [1:0] {
        statusIdle   = 2'b00,
        statusEnded  = 2'b01,
        statusActive = 2'b11
    } comStatus;

    typedef enum logic [2:0] {sessIdle, sessRead, sessDisplay, sessWrite, sessEnd} sessionState;

    typedef enum logic [2:0] {
        reqIdle, reqShift, reqWaitGrant, reqAckPattern, reqGranted, reqRelease
    } reqState;

    typedef enum logic [2:0] {linkIdle, linkCtrl, linkWrite, linkRead, linkEndMark} linkState;

endpackage

// ==== rtl/arbiterRequester.sv ====
`timescale 1ns/1ns
`include "busMaster_macros.svh"

module arbiterRequester (
    input  logic clk,
    input  logic rstN,
    input  logic xferReq,       // level from the session FSM
    input  logic linkDone,
    input  logic arbCont,
    output logic arbSend,
    output logic busGranted,
    output logic xferDone
);

    import busMasterPkg::*;

    // one counter covers the request word and the ack pattern + wait
    localparam int ackLast = 2 + `BM_GRANT_WAIT;
    localparam int cntTop  = (`BM_REQ_LEN > ackLast) ? `BM_REQ_LEN : ackLast;
    localparam int cntW    = $clog2(cntTop + 1);

    reqState               state;
    logic [`BM_REQ_LEN-1:0] reqBits;
    logic [cntW-1:0]       cnt;
    logic [1:0]            arbSync;
    logic                  granted;

    assign granted = &arbSync;  // two high samples in a row

    //////////////////////////////////////////////////////////////////////
    // request / grant sequencing
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= reqIdle;
            cnt        <= '0;
            arbSync    <= '0;
            busGranted <= 1'b0;
            xferDone   <= 1'b0;
        end else begin
            arbSync    <= {arbSync[0], arbCont};
            busGranted <= 1'b0;
            xferDone   <= 1'b0;
            case (state)
                reqIdle:
                    // skip the cycle where the last transfer is still being retired
                    if (xferReq && !xferDone && !arbCont) begin
                        reqBits <= {3'b111, `BM_SLAVE_ID};
                        cnt     <= '0;
                        state   <= reqShift;
                    end
                reqShift: begin
                    reqBits <= reqBits << 1;
                    cnt     <= cnt + 1'b1;
                    if (cnt == cntW'(`BM_REQ_LEN - 1)) begin
                        cnt   <= '0;
                        state <= reqWaitGrant;
                    end
                end
                reqWaitGrant:
                    if (granted) state <= reqAckPattern;  // no timeout here
                reqAckPattern: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == cntW'(ackLast)) begin
                        cnt        <= '0;
                        busGranted <= 1'b1;
                        state      <= reqGranted;
                    end
                end
                reqGranted:
                    if (linkDone) state <= reqRelease;
                reqRelease: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == cntW'(2)) begin
                        cnt      <= '0;
                        xferDone <= 1'b1;
                        state    <= reqIdle;
                    end
                end
                default: state <= reqIdle;
            endcase
        end
    end

    // pin pattern decoded from state and counter
    always_comb begin
        case (state)
            reqShift:      arbSend = reqBits[`BM_REQ_LEN-1];  // msb first
            reqAckPattern: arbSend = (cnt != cntW'(1));       // 1, 0, then held high
            reqGranted:    arbSend = 1'b1;                    // bus owned
            reqRelease:    arbSend = (cnt != cntW'(0));       // 0, 1, 1
            default:       arbSend = 1'b0;
        endcase
    end

endmodule

// ==== rtl/serialLink.sv ====
`timescale 1ns/1ns
`include "busMaster_macros.svh"

module serialLink (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 busGranted,
    input  busMasterPkg::busOp   xferOp,
    input  busMasterPkg::dataByte txByte,
    input  logic                 rD,
    input  logic                 ready,
    output logic                 control,
    output logic                 wrD,
    output logic                 valid,
    output busMasterPkg::readWord rxWord,
    output logic                 linkDone
);

    import busMasterPkg::*;

    localparam int wordBits = 2 * `BM_DATA_WIDTH;
    localparam int bitW     = $clog2(wordBits);

    linkState                state;
    logic [`BM_CTRL_LEN-1:0] ctrlBits;
    dataByte                 wrBits;
    logic [bitW-1:0]         bitCnt;

    //////////////////////////////////////////////////////////////////////
    // slave side pins
    //////////////////////////////////////////////////////////////////////
    assign control = (state == linkCtrl) ? ctrlBits[`BM_CTRL_LEN-1]
                                         : (state == linkEndMark);  // marker
    assign valid   = (state == linkWrite);
    assign wrD     = valid & wrBits[`BM_DATA_WIDTH-1];

    //////////////////////////////////////////////////////////////////////
    // frame, data and marker sequencing
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= linkIdle;
            bitCnt   <= '0;
            linkDone <= 1'b0;
        end else begin
            linkDone <= 1'b0;
            case (state)
                linkIdle:
                    if (busGranted) begin
                        ctrlBits <= {3'b111, `BM_SLAVE_ID, xferOp};
                        wrBits   <= txByte;
                        bitCnt   <= '0;
                        state    <= linkCtrl;
                    end

                linkCtrl: begin
                    ctrlBits <= ctrlBits << 1;
                    bitCnt   <= bitCnt + 1'b1;
                    if (bitCnt == bitW'(`BM_CTRL_LEN - 1)) begin
                        bitCnt <= '0;
                        // r/w bit is on the pin right now
                        state  <= ctrlBits[`BM_CTRL_LEN-1] ? linkWrite : linkRead;
                    end
                end

                linkWrite: begin
                    wrBits <= wrBits << 1;
                    bitCnt <= bitCnt + 1'b1;
                    if (bitCnt == bitW'(`BM_DATA_WIDTH - 1)) begin
                        bitCnt <= '0;
                        state  <= linkEndMark;
                    end
                end

                // ready low just stretches the read
                linkRead:
                    if (ready) begin
                        rxWord <= readWord'({rxWord[wordBits-2:0], rD});
                        bitCnt <= bitCnt + 1'b1;
                        if (bitCnt == bitW'(wordBits - 1)) begin
                            bitCnt <= '0;
                            state  <= linkEndMark;
                        end
                    end

                linkEndMark: begin
                    linkDone <= 1'b1;
                    state    <= linkIdle;
                end

                default: state <= linkIdle;
            endcase
        end
    end

endmodule

// ==== rtl/sessionController.sv ====
`timescale 1ns/1ns
`include "busMaster_macros.svh"

module sessionController (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  start,
    input  logic                  eoc,
    input  logic                  xferDone,
    input  busMasterPkg::readWord rxWord,
    output logic                  xferReq,
    output busMasterPkg::busOp    xferOp,
    output busMasterPkg::dataByte txByte,
    output busMasterPkg::comStatus doneCom,
    output busMasterPkg::dataByte dataOut,
    output logic                  disData
);

    import busMasterPkg::*;

    localparam int dispW = $clog2(`BM_DISPLAY_CYCLES + 1);

    sessionState      state;
    dataByte          dataReg;     // byte being shown / written
    logic [dispW-1:0] dispCnt;
    logic             eocPend;
    logic             endNow;
    logic             launch;

    // eoc waits for any transfer in flight
    assign endNow = (eoc || eocPend) && (!xferReq || xferDone);

    // one transfer at a time
    assign launch = !xferReq && !endNow
                  && ((state == sessRead && !start) || state == sessWrite);

    //////////////////////////////////////////////////////////////////////
    // transfer request
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            xferReq <= 1'b0;
            xferOp  <= opRead;
            eocPend <= 1'b0;
        end else begin
            if (eoc) eocPend <= 1'b1;
            if (xferDone) begin
                xferReq <= 1'b0;
            end else if (launch) begin
                xferReq <= 1'b1;
                xferOp  <= (state == sessWrite) ? opWrite : opRead;
            end
        end
    end

    // held steady for the whole transfer
    always_ff @(posedge clk) begin
        if (launch && !xferDone) txByte <= dataReg;
    end

    //////////////////////////////////////////////////////////////////////
    // session FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= sessIdle;
            dataReg <= '0;
            dispCnt <= '0;
        end else if (state != sessEnd && endNow) begin
            state <= sessEnd;
        end else begin
            case (state)
                sessIdle:
                    if (start) begin
                        dataReg <= `BM_START_DATA;
                        state   <= sessDisplay;
                    end else begin
                        state <= sessRead;  // default is a read
                    end
                sessRead:
                    if (start) begin
                        dataReg <= `BM_START_DATA;  // pending read result dropped
                        state   <= sessDisplay;
                    end else if (xferDone) begin
                        if (rxWord.ackByte == `BM_ACK_BYTE) begin
                            dataReg <= rxWord.payload;
                            state   <= sessDisplay;
                        end else begin
                            state <= sessEnd;  // bad ack
                        end
                    end
                sessDisplay:
                    if (dispCnt == dispW'(`BM_DISPLAY_CYCLES - 1)) begin
                        dispCnt <= '0;
                        dataReg <= dataReg + 1'b1;
                        state   <= sessWrite;
                    end else begin
                        dispCnt <= dispCnt + 1'b1;
                    end
                sessWrite:
                    // an ignored read may finish here first
                    if (xferDone && xferOp == opWrite) state <= sessRead;
                default: state <= sessEnd;
            endcase
        end
    end

    assign disData = (state == sessDisplay);
    assign dataOut = (state == sessDisplay || state == sessEnd) ? dataReg : '0;

    always_comb begin
        case (state)
            sessIdle: doneCom = statusIdle;
            sessEnd:  doneCom = statusEnded;
            default:  doneCom = statusActive;
        endcase
    end

endmodule

// ==== rtl/busMaster.sv ====
`timescale 1ns/1ns

module busMaster (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   start,
    input  logic                   eoc,
    input  logic                   rD,
    input  logic                   ready,
    input  logic                   arbCont,
    output busMasterPkg::comStatus doneCom,
    output busMasterPkg::dataByte  dataOut,
    output logic                   disData,
    output logic                   control,
    output logic                   wrD,
    output logic                   valid,
    output logic                   arbSend
);

    import busMasterPkg::*;

    // controller <-> requester / link
    logic    xferReq;
    logic    xferDone;
    busOp    xferOp;
    dataByte txByte;
    readWord rxWord;
    // requester <-> link
    logic    busGranted;
    logic    linkDone;

    sessionController uSession (
        .clk(clk), .rstN(rstN), .start(start), .eoc(eoc),
        .xferDone(xferDone), .rxWord(rxWord),
        .xferReq(xferReq), .xferOp(xferOp), .txByte(txByte),
        .doneCom(doneCom), .dataOut(dataOut), .disData(disData)
    );

    arbiterRequester uRequester (
        .clk(clk), .rstN(rstN), .xferReq(xferReq), .linkDone(linkDone),
        .arbCont(arbCont), .arbSend(arbSend), .busGranted(busGranted),
        .xferDone(xferDone)
    );

    serialLink uLink (
        .clk(clk), .rstN(rstN), .busGranted(busGranted), .xferOp(xferOp),
        .txByte(txByte), .rD(rD), .ready(ready), .control(control),
        .wrD(wrD), .valid(valid), .rxWord(rxWord), .linkDone(linkDone)
    );

endmodule

// ==== verif/tbClock.sv ====
`timescale 1ns/1ns

module tbClock #(
    parameter int period = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;  // free running
    end

endmodule

// ==== verif/busMaster_props.sv ====
`timescale 1ns/1ns

module busMasterProps (
    input logic                   clk,
    input logic                   rstN,
    input logic                   valid,
    input logic                   control,
    input logic                   disData,
    input busMasterPkg::comStatus doneCom
);

    import busMasterPkg::*;

    //////////////////////////////////////////////////////////////////////
    // slave pins
    //////////////////////////////////////////////////////////////////////
    // frame and marker never overlap a write bit
    validNotControl: assert property (
        @(posedge clk) disable iff (!rstN) !(valid && control)
    ) else $error("valid and control high in the same cycle");

    //////////////////////////////////////////////////////////////////////
    // session outputs
    //////////////////////////////////////////////////////////////////////
    statusLegal: assert property (
        @(posedge clk) disable iff (!rstN) doneCom != 2'b10
    ) else $error("doneCom carries the unused code 10");

    // display finishes before the write goes out
    noDisplayInWrite: assert property (
        @(posedge clk) disable iff (!rstN) !(disData && valid)
    ) else $error("disData high while a write byte is on wrD");

endmodule

bind busMaster busMasterProps uProps (
    .clk(clk),
    .rstN(rstN),
    .valid(valid),
    .control(control),
    .disData(disData),
    .doneCom(doneCom)
);

// ==== verif/busMasterTb.sv ====
`timescale 1ns/1ns
`include "busMaster_macros.svh"

module busMasterTb;

    import busMasterPkg::*;

    localparam int waitLimit = 400;   // cycles, per wait loop

    logic     clk;
    logic     rstN;
    logic     start;
    logic     eoc;
    logic     rD;
    logic     ready;
    logic     arbCont;
    comStatus doneCom;
    dataByte  dataOut;
    logic     disData;
    logic     control;
    logic     wrD;
    logic     valid;
    logic     arbSend;
    int       errorCount;

    tbClock #(.period(20)) uClock (.clk(clk));

    busMaster dut (
        .clk(clk), .rstN(rstN), .start(start), .eoc(eoc), .rD(rD), .ready(ready),
        .arbCont(arbCont), .doneCom(doneCom), .dataOut(dataOut), .disData(disData),
        .control(control), .wrD(wrD), .valid(valid), .arbSend(arbSend)
    );

    //////////////////////////////////////////////////////////////////////
    // failure reporting and compares
    //////////////////////////////////////////////////////////////////////
    task automatic failNow();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic abortRun(input string why);
        errorCount++;
        $display("%s", why);
        failNow();
    endtask

    task automatic checkByte(input string name, input dataByte got, input dataByte exp);
        if (got !== exp) begin
            errorCount++;
            $display("FAILED at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            failNow();
        end
    endtask

    task automatic checkStatus(input string name, input comStatus got, input comStatus exp);
        if (got !== exp) begin
            errorCount++;
            $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            failNow();
        end
    endtask

    // frames, single pins and cycle counts
    task automatic checkBits(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("FAILED at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            failNow();
        end
    endtask

    task automatic stepWait(inout int cnt, input string what);
        @(negedge clk);
        cnt++;
        if (cnt > waitLimit) abortRun({"timeout while waiting for ", what});
    endtask

    //////////////////////////////////////////////////////////////////////
    // reset and session end
    //////////////////////////////////////////////////////////////////////
    task automatic applyReset();
        @(posedge clk);
        #2;
        rstN    = 1'b0;
        start   = 1'b0;
        eoc     = 1'b0;
        rD      = 1'b0;
        ready   = 1'b0;
        arbCont = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        checkBits("control", control, 0);
        checkBits("wrD", wrD, 0);
        checkBits("valid", valid, 0);
        checkBits("arbSend", arbSend, 0);
        checkBits("disData", disData, 0);
        checkByte("dataOut", dataOut, 0);
        checkStatus("doneCom", doneCom, statusIdle);
        @(posedge clk);
        #2 rstN = 1'b1;
    endtask

    task automatic waitEnded(input dataByte lastByte);
        int cnt;
        cnt = 0;
        do stepWait(cnt, "doneCom to show the end"); while (doneCom !== statusEnded);
        checkByte("dataOut", dataOut, lastByte);
        // no new request once ended
        repeat (60) begin
            @(negedge clk);
            if (arbSend) abortRun("a bus request appeared after the session ended");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // display, arbiter and slave models
    //////////////////////////////////////////////////////////////////////
    task automatic showByte(input dataByte exp);
        int cnt;
        int n;
        cnt = 0;
        n   = 0;
        do stepWait(cnt, "disData"); while (!disData);
        while (disData) begin
            checkByte("dataOut", dataOut, exp);
            checkStatus("doneCom", doneCom, statusActive);
            n++;
            if (n > 2 * `BM_DISPLAY_CYCLES) abortRun("disData stuck high");
            @(negedge clk);
        end
        checkBits("disData cycles", n, `BM_DISPLAY_CYCLES);
    endtask

    task automatic checkRelease();
        int cnt;
        cnt = 0;
        do stepWait(cnt, "release pattern"); while (arbSend);
        @(negedge clk);
        checkBits("arbSend release", arbSend, 1);
        @(negedge clk);
        checkBits("arbSend release", arbSend, 1);
        @(negedge clk);
        checkBits("arbSend release", arbSend, 0);
    endtask

    task automatic serveTransfer(input busOp op, input logic [15:0] word,
                                 input bit injectStart, input dataByte expWrite);
        int         cnt;
        int         i;
        int         n;
        int         idx;
        int         delay;
        bit         r;
        logic [5:0] req;
        logic [6:0] frame;
        dataByte    wBits;
        cnt = 0;
        do stepWait(cnt, "request word on arbSend"); while (!arbSend);
        req[5] = arbSend;
        for (i = 4; i >= 0; i--) begin
            @(negedge clk);
            req[i] = arbSend;
        end
        checkBits("arbSend request", req, {3'b111, `BM_SLAVE_ID});
        if (injectStart) begin  // start lands while the read waits for grant
            @(posedge clk);
            #2 start = 1'b1;
            @(posedge clk);
            #2 start = 1'b0;
        end
        delay = $urandom_range(0, 6);
        repeat (delay) @(posedge clk);
        @(posedge clk);
        #2 arbCont = 1'b1;
        cnt = 0;
        do stepWait(cnt, "control frame"); while (!control);
        frame[6] = control;
        for (i = 5; i >= 0; i--) begin
            @(negedge clk);
            frame[i] = control;
        end
        checkBits("control frame", frame, {3'b111, `BM_SLAVE_ID, op});
        @(posedge clk);
        #2 arbCont = 1'b0;
        if (op == opWrite) begin
            cnt = 0;
            n   = 0;
            do stepWait(cnt, "valid"); while (!valid);
            while (valid) begin
                wBits = {wBits[`BM_DATA_WIDTH-2:0], wrD};
                n++;
                if (n > 16) abortRun("valid stuck high");
                @(negedge clk);
            end
            checkBits("valid cycles", n, `BM_DATA_WIDTH);
            checkByte("wrD byte", wBits, expWrite);
            checkBits("control end marker", control, 1);
        end else begin
            idx = 0;
            cnt = 0;
            while (idx < 16) begin
                r     = ($urandom_range(0, 3) != 0);  // about one stall in four
                ready = r;
                rD    = r ? word[15 - idx] : 1'($urandom_range(0, 1));
                if (r) idx++;
                @(posedge clk);
                #2;
                cnt++;
                if (cnt > waitLimit) abortRun("read did not finish");
            end
            ready = 1'b0;
            rD    = 1'b0;
            @(negedge clk);
            checkBits("control end marker", control, 1);
        end
        checkRelease();
    endtask

    //////////////////////////////////////////////////////////////////////
    // sessions with a reference model of the data byte
    //////////////////////////////////////////////////////////////////////
    initial begin
        int       cnt;
        int       s;
        int       rd;
        int       rounds;
        bit       ended;
        bit       injectStart;
        bit       badAck;
        dataByte  payload;
        dataByte  ackByte;
        dataByte  shown;
        dataByte  lastByte;
        rstN       = 1'b0;
        start      = 1'b0;
        eoc        = 1'b0;
        rD         = 1'b0;
        ready      = 1'b0;
        arbCont    = 1'b0;
        errorCount = 0;
        void'($urandom(24127));
        for (s = 0; s < 5; s++) begin
            applyReset();
            lastByte = '0;  // data register reset value
            ended    = 1'b0;
            rounds   = $urandom_range(2, 5);
            for (rd = 0; rd < rounds && !ended; rd++) begin
                injectStart = ($urandom_range(0, 3) == 0);
                badAck      = !injectStart && ($urandom_range(0, 7) == 0);
                payload     = dataByte'($urandom_range(0, 255));
                ackByte     = `BM_ACK_BYTE;
                if (badAck) ackByte = `BM_ACK_BYTE ^ dataByte'($urandom_range(1, 255));
                if (injectStart) begin
                    fork
                        serveTransfer(opRead, {ackByte, payload}, 1'b1, '0);
                        showByte(`BM_START_DATA);
                    join
                    shown = `BM_START_DATA;  // read result is dropped
                end else begin
                    serveTransfer(opRead, {ackByte, payload}, 1'b0, '0);
                    shown = payload;
                    if (badAck) begin
                        waitEnded(lastByte);
                        ended = 1'b1;
                    end else if (rd == rounds - 1) begin
                        cnt = 0;
                        do stepWait(cnt, "disData"); while (!disData);
                        checkByte("dataOut", dataOut, shown);
                        @(posedge clk);
                        #2 eoc = 1'b1;
                        @(posedge clk);
                        #2 eoc = 1'b0;
                        waitEnded(shown);
                        ended = 1'b1;
                    end else begin
                        showByte(shown);
                    end
                end
                if (!ended) begin
                    serveTransfer(opWrite, '0, 1'b0, shown + 1'b1);
                    lastByte = shown + 1'b1;
                end
            end
        end
        if (errorCount == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/busMasterPkg.sv
rtl/arbiterRequester.sv
rtl/serialLink.sv
rtl/sessionController.sv
rtl/busMaster.sv
verif/tbClock.sv
verif/busMaster_props.sv
verif/busMasterTb.sv
